/* all.f */
+incdir+.
sha1_pkg.sv
sha1_input_stage.sv
sha1_round_stage.sv
sha1_digest_stage.sv
sha1_top.sv
tb_sha1_top.sv

/* sha1_digest_stage.sv */
// last pipeline register; adds the carried chaining value to the final state to finish the digest
`default_nettype none
`timescale 1ns/10ps

module sha1_digest_stage
	import sha1_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic valid_in,
	input wire sha1_state_u state_in,
	input wire digest_t ctx_in,
	output logic out_valid,
	output digest_t out_digest
);

	digest_t sum;

	// feed-forward, each word wraps on its own
	always_comb
	begin
		for (int i = 0; i < state_words; i++)
		begin
			sum[i * word_bits +: word_bits] = state_in.flat[i * word_bits +: word_bits]
				+ ctx_in[i * word_bits +: word_bits];
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= valid_in;
	end

	always_ff @(posedge clk)
	begin
		out_digest <= sum;
	end

	// reset has to reach every valid register along the whole chain
	a_valid_known: assert property (@(posedge clk) $past(rst_n) |-> !$isunknown(out_valid))
		else $error("out_valid unknown after reset");

endmodule

`default_nettype wire

/* sha1_input_stage.sv */
// first pipeline register; loads the chaining value and the padded sixteen-word schedule window
`default_nettype none
`timescale 1ns/10ps

module sha1_input_stage
	import sha1_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic in_valid,
	input wire digest_t in_ctx,
	input wire digest_t in_data,
	output logic valid,
	output sha1_state_u state,
	output window_t window,
	output digest_t ctx
);

	window_t block;

	// five data words, marker, zeros, then the bit length
	always_comb
	begin
		block = '0;
		for (int i = 0; i < msg_words; i++)
		begin
			// first message word is the top word of in_data
			block[i] = in_data[digest_bits - 1 - i * word_bits -: word_bits];
		end
		block[msg_words] = pad_marker;
		block[window_words - 1] = pad_length;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			valid <= 1'b0;
		else
			valid <= in_valid;
	end

	// chaining value seeds the working state and rides along for the final add
	always_ff @(posedge clk)
	begin
		state.flat <= in_ctx;
		ctx <= in_ctx;
		window <= block;
	end

	a_valid_cleared: assert property (@(posedge clk) !rst_n |=> !valid)
		else $error("input stage valid set in the cycle after reset");

endmodule

`default_nettype wire

/* sha1_pkg.sv */
// SHA-1 widths, constants and shared types; every pipeline stage and the testbench import this
`default_nettype none

package sha1_pkg;

	// word and block geometry
	localparam int word_bits = 32;
	localparam int state_words = 5;
	localparam int digest_bits = state_words * word_bits;
	localparam int msg_words = 5;
	localparam int window_words = 16;
	localparam int round_count = 80;

	// input register, one register per round, feed-forward register
	localparam int pipe_latency = round_count + 2;

	typedef logic [word_bits-1:0] word_t;

	// chaining values, messages and digests; word a sits in the top bits
	typedef logic [digest_bits-1:0] digest_t;

	// the five working variables, a in the high word
	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		word_t e;
	} sha1_vars_t;

	// same 160 bits seen flat (ports, feed-forward) or as variables (rounds)
	typedef union packed {
		digest_t flat;
		sha1_vars_t vars;
	} sha1_state_u;

	// schedule words t .. t+15, entry 0 feeds the current round
	typedef word_t [window_words-1:0] window_t;

	// round constants
	localparam word_t k_00_19 = 32'h5a827999;
	localparam word_t k_20_39 = 32'h6ed9eba1;
	localparam word_t k_40_59 = 32'h8f1bbcdc;
	localparam word_t k_60_79 = 32'hca62c1d6;

	// fixed padding of the second HMAC block
	localparam word_t pad_marker = 32'h80000000;

	// 64-byte pad block plus 20 message bytes = 672 bits
	localparam word_t pad_length = 32'h000002a0;

endpackage

`default_nettype wire

/* sha1_round_stage.sv */
// one registered SHA-1 round with one message schedule step, replicated eighty times by the top level
`default_nettype none
`timescale 1ns/10ps

module sha1_round_stage
	import sha1_pkg::*;
#(
	parameter int round_index = 0
)
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic valid_in,
	input wire sha1_state_u state_in,
	input wire window_t window_in,
	input wire digest_t ctx_in,
	output logic valid_out,
	output sha1_state_u state_out,
	output window_t window_out,
	output digest_t ctx_out
);

	// constant for this round's range
	localparam word_t round_k =
		(round_index < 20) ? k_00_19 :
		(round_index < 40) ? k_20_39 :
		(round_index < 60) ? k_40_59 : k_60_79;

	// W[t+16] is only consumed up to round 79
	localparam bit extend_schedule = (round_index < round_count - window_words);

	sha1_state_u next_state;
	window_t next_window;
	word_t sched_word;

	function automatic word_t rotl(input word_t x, input int n);
		return (x << n) | (x >> (word_bits - n));
	endfunction

	// choose, parity, majority, parity
	function automatic word_t round_f(input word_t b, input word_t c, input word_t d);
		if (round_index < 20)
			return (b & c) | (~b & d);
		else if (round_index < 40)
			return b ^ c ^ d;
		else if (round_index < 60)
			return (b & c) | (b & d) | (c & d);
		else
			return b ^ c ^ d;
	endfunction

	always_comb
	begin
		next_state.vars.a = rotl(state_in.vars.a, 5)
			+ round_f(state_in.vars.b, state_in.vars.c, state_in.vars.d)
			+ state_in.vars.e + round_k + window_in[0];
		next_state.vars.b = state_in.vars.a;
		next_state.vars.c = rotl(state_in.vars.b, 30);
		next_state.vars.d = state_in.vars.c;
		next_state.vars.e = state_in.vars.d;
	end

	// new schedule word from entries 0, 2, 8 and 13 of the window
	always_comb
	begin
		if (extend_schedule)
			sched_word = rotl(window_in[0] ^ window_in[2] ^ window_in[8] ^ window_in[13], 1);
		else
			sched_word = '0;
	end

	// slide the window down one word, new word on top
	always_comb
	begin
		for (int i = 0; i < window_words - 1; i++)
		begin
			next_window[i] = window_in[i + 1];
		end
		next_window[window_words - 1] = sched_word;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			valid_out <= 1'b0;
		else
			valid_out <= valid_in;
	end

	always_ff @(posedge clk)
	begin
		state_out <= next_state;
		window_out <= next_window;
		ctx_out <= ctx_in;
	end

	// strobe moves exactly one stage per clock outside reset
	a_valid_step: assert property (
		@(posedge clk) (rst_n && $past(rst_n)) |-> (valid_out == $past(valid_in)))
		else $error("round %0d valid did not follow its input by one cycle", round_index);

endmodule

`default_nettype wire

/* sha1_top.sv */
// fully unrolled SHA-1 second-block engine for HMAC-SHA1, one digest per clock after 82 cycles
`default_nettype none
`timescale 1ns/10ps

module sha1_top
	import sha1_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic in_valid,
	input wire digest_t in_ctx,
	input wire digest_t in_data,
	output logic out_valid,
	output digest_t out_digest
);

	// index 0 is the input stage output, index r+1 the output of round r
	logic valid_s [round_count + 1];
	sha1_state_u state_s [round_count + 1];
	window_t window_s [round_count + 1];
	digest_t ctx_s [round_count + 1];

	sha1_input_stage u_input (
		.clk (clk),
		.rst_n (rst_n),
		.in_valid (in_valid),
		.in_ctx (in_ctx),
		.in_data (in_data),
		.valid (valid_s[0]),
		.state (state_s[0]),
		.window (window_s[0]),
		.ctx (ctx_s[0])
	);

	// one stage per round
	for (genvar r = 0; r < round_count; r++)
	begin : g_round
		sha1_round_stage #(
			.round_index (r)
		) u_round (
			.clk (clk),
			.rst_n (rst_n),
			.valid_in (valid_s[r]),
			.state_in (state_s[r]),
			.window_in (window_s[r]),
			.ctx_in (ctx_s[r]),
			.valid_out (valid_s[r + 1]),
			.state_out (state_s[r + 1]),
			.window_out (window_s[r + 1]),
			.ctx_out (ctx_s[r + 1])
		);
	end

	// window of the last round has no consumer, synthesis drops it
	sha1_digest_stage u_digest (
		.clk (clk),
		.rst_n (rst_n),
		.valid_in (valid_s[round_count]),
		.state_in (state_s[round_count]),
		.ctx_in (ctx_s[round_count]),
		.out_valid (out_valid),
		.out_digest (out_digest)
	);

endmodule

`default_nettype wire

/* tb_sha1_model.svh */
// reference SHA-1 compression of the padded second HMAC block, included inside the testbench module
`ifndef TB_SHA1_MODEL_SVH
`define TB_SHA1_MODEL_SVH

// expected digest for one chaining value and one 160-bit message
function automatic digest_t sha1_model(input digest_t ctx, input digest_t msg);
	word_t w [0:79];
	word_t h [0:4];
	word_t a;
	word_t b;
	word_t c;
	word_t d;
	word_t e;
	word_t f;
	word_t k;
	word_t tmp;
	digest_t res;

	for (int i = 0; i < 16; i++)
	begin
		w[i] = 32'h0;
	end
	// first word of each value sits in the top bits
	for (int i = 0; i < 5; i++)
	begin
		w[i] = msg[159 - 32 * i -: 32];
		h[i] = ctx[159 - 32 * i -: 32];
	end
	w[5] = 32'h80000000;
	w[15] = 32'h000002a0;

	for (int i = 16; i < 80; i++)
	begin
		tmp = w[i - 3] ^ w[i - 8] ^ w[i - 14] ^ w[i - 16];
		w[i] = {tmp[30:0], tmp[31]};
	end

	a = h[0];
	b = h[1];
	c = h[2];
	d = h[3];
	e = h[4];
	for (int t = 0; t < 80; t++)
	begin
		if (t < 20)
		begin
			f = (b & c) | (~b & d);
			k = 32'h5a827999;
		end
		else if (t < 40)
		begin
			f = b ^ c ^ d;
			k = 32'h6ed9eba1;
		end
		else if (t < 60)
		begin
			f = (b & c) | (b & d) | (c & d);
			k = 32'h8f1bbcdc;
		end
		else
		begin
			f = b ^ c ^ d;
			k = 32'hca62c1d6;
		end
		tmp = {a[26:0], a[31:27]} + f + e + k + w[t];
		e = d;
		d = c;
		c = {b[1:0], b[31:2]};
		b = a;
		a = tmp;
	end

	// feed-forward, each word wraps on its own
	res = {a + h[0], b + h[1], c + h[2], d + h[3], e + h[4]};
	return res;
endfunction

`endif

/* tb_sha1_top.sv */
// self-checking testbench for sha1_top; random and corner items checked against a reference model
`default_nettype none
`timescale 1ns/10ps

module tb_sha1_top
	import sha1_pkg::*;
();

	localparam int reset_cycles = 10;
	localparam int n_stream = 300;
	localparam int n_gappy = 150;
	localparam int max_gap = 3;
	localparam int n_corner = 9;
	localparam int n_pre_reset = 60;
	localparam int n_post_reset = 40;
	localparam int n_phases = 5;
	localparam int drain_limit = pipe_latency + 10;

	// every phase issues its items, then drains the pipeline
	localparam int timeout_cycles = 2 * reset_cycles + 1 + n_stream
		+ n_gappy * (max_gap + 1) + n_corner + n_pre_reset + n_post_reset
		+ n_phases * (drain_limit + 2) + 200;

	localparam digest_t sha1_init = 160'h67452301_efcdab89_98badcfe_10325476_c3d2e1f0;

	logic clk;
	logic rst_n;
	logic in_valid;
	digest_t in_ctx;
	digest_t in_data;
	logic out_valid;
	digest_t out_digest;

	int cycle = 0;
	int value_errors = 0;
	int latency_errors = 0;
	int other_errors = 0;
	int compared = 0;
	logic prev_rst_n = 1'b1;
	digest_t exp_digest_q [$];
	int exp_cycle_q [$];
	digest_t exp_d;
	int exp_c;
	int unsigned seed;
	int unsigned dummy;

	`include "tb_sha1_model.svh"

	sha1_top uut (
		.clk (clk),
		.rst_n (rst_n),
		.in_valid (in_valid),
		.in_ctx (in_ctx),
		.in_data (in_data),
		.out_valid (out_valid),
		.out_digest (out_digest)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
	end

	function automatic digest_t rand_digest();
		digest_t v;
		for (int i = 0; i < state_words; i++)
		begin
			v[i * 32 +: 32] = $urandom();
		end
		return v;
	endfunction

	task automatic check_digest(input string name, input digest_t got, input digest_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_latency(input string name, input int got, input int exp);
		if (got != exp)
		begin
			latency_errors++;
			$display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	// called 1 ns after a rising edge; item is sampled at the next edge
	task automatic issue_item(input digest_t ctx, input digest_t data);
		in_valid = 1'b1;
		in_ctx = ctx;
		in_data = data;
		exp_digest_q.push_back(sha1_model(ctx, data));
		// issue cycle is the one the strobe is driven in
		exp_cycle_q.push_back(cycle);
		@(posedge clk);
		#1;
	endtask

	task automatic idle_cycle();
		in_valid = 1'b0;
		in_ctx = rand_digest();
		in_data = rand_digest();
		@(posedge clk);
		#1;
	endtask

	// wait for all outstanding items but no longer than the pipeline depth plus margin
	task automatic drain();
		int n;
		n = 0;
		while (exp_digest_q.size() != 0 && n < drain_limit)
		begin
			idle_cycle();
			n++;
		end
		if (exp_digest_q.size() != 0)
		begin
			other_errors++;
			$display("%0d issued items never came out of the pipeline", exp_digest_q.size());
			exp_digest_q.delete();
			exp_cycle_q.delete();
		end
	endtask

	// scoreboard sampled on the falling edge
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			// reset was seen by the previous rising edge
			if (!prev_rst_n && out_valid !== 1'b0)
			begin
				other_errors++;
				$display("out_valid not low while reset is applied at %0t", $time);
			end
		end
		else if (out_valid === 1'b1)
		begin
			if (exp_digest_q.size() == 0)
			begin
				other_errors++;
				$display("out_valid high at %0t with no item outstanding", $time);
			end
			else
			begin
				exp_d = exp_digest_q.pop_front();
				exp_c = exp_cycle_q.pop_front();
				check_digest("out_digest", out_digest, exp_d);
				check_latency("out_valid arrival cycle", cycle, exp_c + pipe_latency);
				compared++;
			end
		end
		else if (out_valid !== 1'b0)
		begin
			other_errors++;
			$display("out_valid unknown at %0t", $time);
		end
		prev_rst_n = rst_n;
	end

	initial
	begin
		while (cycle < timeout_cycles)
			@(posedge clk);
		$display("run stopped after %0d cycles without finishing", cycle);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		digest_t corner [0:2];
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_ctx = '0;
		in_data = '0;
		seed = 32'h5764;
		dummy = $urandom(seed);
		corner[0] = '0;
		corner[1] = '1;
		corner[2] = {5{32'h7fffffff}};

		repeat (reset_cycles) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// single item from the standard initial value
		issue_item(sha1_init, rand_digest());
		drain();

		// back-to-back stream
		for (int i = 0; i < n_stream; i++)
		begin
			issue_item(rand_digest(), rand_digest());
		end
		drain();

		// random gaps between items
		for (int i = 0; i < n_gappy; i++)
		begin
			issue_item(rand_digest(), rand_digest());
			repeat ($urandom_range(max_gap, 0)) idle_cycle();
		end
		drain();

		// carry wrap in round and feed-forward adders
		for (int i = 0; i < 3; i++)
		begin
			for (int j = 0; j < 3; j++)
			begin
				issue_item(corner[i], corner[j]);
			end
		end
		drain();

		// reset in the middle of a stream
		for (int i = 0; i < n_pre_reset; i++)
		begin
			issue_item(rand_digest(), rand_digest());
		end
		rst_n = 1'b0;
		exp_digest_q.delete();
		exp_cycle_q.delete();
		// strobes during reset must be dropped
		repeat (reset_cycles)
		begin
			in_valid = ($urandom_range(1, 0) == 1);
			in_ctx = rand_digest();
			in_data = rand_digest();
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
		rst_n = 1'b1;
		for (int i = 0; i < n_post_reset; i++)
		begin
			issue_item(rand_digest(), rand_digest());
		end
		drain();

		repeat (4) idle_cycle();
		$display("%0d digests compared, %0d value errors, %0d latency errors, %0d other errors",
			compared, value_errors, latency_errors, other_errors);
		if (value_errors == 0 && latency_errors == 0 && other_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
